//--- octree_defines.svh
`ifndef OCTREE_DEFINES_SVH
`define OCTREE_DEFINES_SVH

// tree geometry
`define OCT_TREE_LEVEL      4
`define OCT_MAX_TREES       4
`define OCT_TREE_STRIDE     19

// local memory map, in 64-bit words
`define OCT_TREE_START      0
`define OCT_FEATURE_START   80
`define OCT_FEATURE_LENGTH  10

// first node slot of each level inside a tree
`define OCT_SLOT_BASE_L1    1
`define OCT_SLOT_BASE_L2    9

// feature hash
`define OCT_PRIME_0         31
`define OCT_PRIME_1         29
`define OCT_PRIME_2         23
`define OCT_PRIME_3         19
`define OCT_HASH_LIMIT      54
`define OCT_HASH_SHIFT      36

// queue depths
`define OCT_CHILD_DEPTH     16
`define OCT_ANCHOR_DEPTH    128

`endif

//--- octree_geom_pkg.sv
`include "octree_defines.svh"

package octree_geom_pkg;

  typedef logic [1:0] level_t;
  typedef logic [2:0] offset_t;

  // {level, offset0 .. offset3}, offset0 is the tree index
  typedef logic [2+3*`OCT_TREE_LEVEL-1:0] node_pos_t;

  typedef logic [7:0] child_mask_t;
  typedef logic [3:0] ones_count_t;

  // eight offsets, entry k at bits 3k+2:3k
  typedef logic [23:0] ones_list_t;

  // {position, ones list, ones count}
  typedef logic [41:0] queue_entry_t;

  typedef logic [9:0]  sram_addr_t;
  typedef logic [63:0] sram_word_t;
  typedef logic [3:0]  tree_idx_t;

endpackage

//--- search_ctrl_pkg.sv
package search_ctrl_pkg;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_SEARCH,
    SEQ_OUT,
    SEQ_DONE
  } seq_state_t;

  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_ROOT,
    FETCH_POP,
    FETCH_WAIT,
    FETCH_EXPAND,
    FETCH_DRAIN
  } fetch_state_t;

  typedef enum logic [1:0] {
    GATH_IDLE,
    GATH_POP,
    GATH_WAIT,
    GATH_READ
  } gather_state_t;

endpackage

//--- anchor_fifo.sv
`timescale 1ns/1ns

module anchor_fifo #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 42
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

  // storage and registered read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // queue depths are sized so that neither side ever has to wait
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) full |-> !wr_en);
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) empty |-> !rd_en);

endmodule

//--- node_fetch.sv
`timescale 1ns/1ns
`include "octree_defines.svh"

module node_fetch
  import octree_geom_pkg::*;
  import search_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_start,
  input  tree_idx_t                  tree_idx,
  input  logic [`OCT_TREE_LEVEL-1:0] lod_mask,
  input  sram_word_t                 mem_rdata,
  input  queue_entry_t               child_rd_data,
  input  logic                       child_empty,
  output sram_addr_t                 fetch_addr,
  output logic                       fetch_cen,
  output logic                       child_wr_en,
  output queue_entry_t               child_wr_data,
  output logic                       child_rd_en,
  output logic                       anchor_wr_en,
  output queue_entry_t               anchor_wr_data,
  output logic                       fetch_done
);

  fetch_state_t state;

  // request stage
  node_pos_t   req_pos;
  logic        req_valid;
  logic [6:0]  slot;
  ones_count_t exp_idx;
  node_pos_t   exp_pos;

  // popped child entry
  node_pos_t   ent_pos;
  ones_list_t  ent_list;
  ones_count_t ent_cnt;

  // response stage
  logic        rd_valid;
  node_pos_t   rd_pos;
  logic [1:0]  rd_lane;
  level_t      rd_lvl;
  level_t      push_lvl;
  logic [15:0] lane_bits;
  child_mask_t child_mask;
  child_mask_t anchor_mask;
  ones_list_t  child_list;
  ones_list_t  anchor_list;
  ones_count_t child_cnt;
  ones_count_t anchor_cnt;
  logic        busy;

  // set bits of a mask, lowest first
  function automatic void decode_mask(input child_mask_t m, output ones_list_t list,
                                      output ones_count_t cnt);
    ones_count_t n;
    n    = '0;
    list = '0;
    for (int j = 0; j < 8; j++) begin
      if (m[j]) begin
        list[3*n +: 3] = offset_t'(j);
        n              = n + 1'b1;
      end
    end
    cnt = n;
  endfunction

  assign {ent_pos, ent_list, ent_cnt} = child_rd_data;

  ////////////////////
  // node address
  ////////////////////

  always_comb begin
    case (req_pos[13:12])
      2'd0:    slot = '0;
      2'd1:    slot = 7'(`OCT_SLOT_BASE_L1) + 7'(req_pos[8:6]);
      default: slot = 7'(`OCT_SLOT_BASE_L2) + {1'b0, req_pos[8:6], 3'b000} + 7'(req_pos[5:3]);
    endcase
  end

  // four 16-bit lanes per word
  assign fetch_addr = sram_addr_t'(`OCT_TREE_START)
                    + sram_addr_t'(`OCT_TREE_STRIDE) * sram_addr_t'(req_pos[11:9])
                    + sram_addr_t'(slot[6:2]);
  assign fetch_cen  = ~req_valid;

  // next child of the popped entry
  always_comb begin
    exp_pos = ent_pos;
    exp_pos[11 - 3*ent_pos[13:12] -: 3] = ent_list[3*exp_idx +: 3];
  end

  assign busy = req_valid | rd_valid | child_wr_en | anchor_wr_en;

  ////////////////////
  // walk FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= FETCH_IDLE;
      req_valid   <= 1'b0;
      req_pos     <= '0;
      exp_idx     <= '0;
      child_rd_en <= 1'b0;
      fetch_done  <= 1'b0;
    end else begin
      req_valid   <= 1'b0;
      child_rd_en <= 1'b0;
      fetch_done  <= 1'b0;
      case (state)
        FETCH_IDLE: begin
          if (fetch_start) begin
            state <= FETCH_ROOT;
          end
        end
        FETCH_ROOT: begin
          req_pos   <= {2'd0, offset_t'(tree_idx[2:0]), 9'd0};
          req_valid <= 1'b1;
          state     <= FETCH_DRAIN;
        end
        FETCH_POP: begin
          if (!child_empty) begin
            child_rd_en <= 1'b1;
            state       <= FETCH_WAIT;
          end else begin
            fetch_done <= 1'b1;
            state      <= FETCH_IDLE;
          end
        end
        // entry lands on rd_data here
        FETCH_WAIT: begin
          exp_idx <= '0;
          state   <= FETCH_EXPAND;
        end
        FETCH_EXPAND: begin
          req_pos   <= exp_pos;
          req_valid <= 1'b1;
          if (exp_idx == ent_cnt - 1'b1) begin
            state <= FETCH_DRAIN;
          end else begin
            exp_idx <= exp_idx + 1'b1;
          end
        end
        // let queued pushes settle before checking for empty
        FETCH_DRAIN: begin
          if (!busy) begin
            state <= FETCH_POP;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  ////////////////////
  // mask decode and queue push
  ////////////////////

  assign rd_lvl    = rd_pos[13:12];
  assign push_lvl  = rd_lvl + 2'd1;
  assign lane_bits = mem_rdata[16*rd_lane +: 16];

  always_comb begin
    for (int j = 0; j < 8; j++) begin
      child_mask[j]  = lane_bits[2*j];
      anchor_mask[j] = lane_bits[2*j+1];
    end
    decode_mask(child_mask, child_list, child_cnt);
    decode_mask(anchor_mask, anchor_list, anchor_cnt);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid     <= 1'b0;
      rd_pos       <= '0;
      rd_lane      <= '0;
      child_wr_en  <= 1'b0;
      anchor_wr_en <= 1'b0;
    end else begin
      rd_valid     <= req_valid;
      rd_pos       <= req_pos;
      rd_lane      <= slot[1:0];
      // nodes stop at level 2
      child_wr_en  <= rd_valid && (child_cnt != '0) && (rd_lvl < 2'd2) && lod_mask[push_lvl];
      anchor_wr_en <= rd_valid && (anchor_cnt != '0) && lod_mask[rd_lvl];
    end
  end

  always_ff @(posedge clk) begin
    child_wr_data  <= {push_lvl, rd_pos[11:0], child_list, child_cnt};
    anchor_wr_data <= {push_lvl, rd_pos[11:0], anchor_list, anchor_cnt};
  end

endmodule

//--- feature_gather.sv
`timescale 1ns/1ns
`include "octree_defines.svh"

module feature_gather
  import octree_geom_pkg::*;
  import search_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         search_start,
  input  logic         gather_start,
  input  queue_entry_t anchor_rd_data,
  input  logic         anchor_empty,
  input  sram_word_t   mem_rdata,
  output logic         anchor_rd_en,
  output sram_addr_t   gather_addr,
  output logic         gather_cen,
  output logic         out_cen,
  output logic         out_gwen,
  output sram_addr_t   out_addr,
  output sram_word_t   out_wdata,
  output logic         gather_done
);

  localparam logic [7:0] PRIMES [4] = '{`OCT_PRIME_0, `OCT_PRIME_1, `OCT_PRIME_2, `OCT_PRIME_3};

  gather_state_t state;

  node_pos_t   ent_pos;
  ones_list_t  ent_list;
  ones_count_t ent_cnt;
  ones_count_t anc_idx;
  logic [3:0]  word_idx;

  node_pos_t   anc_pos;
  logic [7:0]  hash_acc;
  logic [5:0]  hash_low;
  logic [6:0]  code;

  logic        rd_valid;
  logic        out_we;
  sram_addr_t  out_ptr;

  assign {ent_pos, ent_list, ent_cnt} = anchor_rd_data;

  ////////////////////
  // anchor position and hash
  ////////////////////

  always_comb begin
    anc_pos = ent_pos;
    anc_pos[11 - 3*ent_pos[13:12] -: 3] = ent_list[3*anc_idx +: 3];
    hash_acc = '0;
    // only offsets up to the anchor level take part
    for (int i = 0; i < `OCT_TREE_LEVEL; i++) begin
      if (i <= int'(ent_pos[13:12])) begin
        hash_acc = hash_acc ^ ((8'(anc_pos[11-3*i -: 3]) + 8'd1) * PRIMES[i]);
      end
    end
  end

  assign hash_low = hash_acc[5:0];
  assign code     = (hash_low > 6'(`OCT_HASH_LIMIT)) ? 7'(hash_low)
                                                     : 7'(hash_low) + 7'(`OCT_HASH_SHIFT);

  assign gather_addr = sram_addr_t'(`OCT_FEATURE_START)
                     + sram_addr_t'(`OCT_FEATURE_LENGTH) * sram_addr_t'(code)
                     + sram_addr_t'(word_idx);
  assign gather_cen  = (state != GATH_READ);

  ////////////////////
  // drain FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= GATH_IDLE;
      anc_idx      <= '0;
      word_idx     <= '0;
      anchor_rd_en <= 1'b0;
      gather_done  <= 1'b0;
    end else begin
      anchor_rd_en <= 1'b0;
      gather_done  <= 1'b0;
      case (state)
        GATH_IDLE: begin
          if (gather_start) begin
            state <= GATH_POP;
          end
        end
        GATH_POP: begin
          if (!anchor_empty) begin
            anchor_rd_en <= 1'b1;
            state        <= GATH_WAIT;
          end else begin
            // lands together with the last output write
            gather_done <= 1'b1;
            state       <= GATH_IDLE;
          end
        end
        GATH_WAIT: begin
          anc_idx  <= '0;
          word_idx <= '0;
          state    <= GATH_READ;
        end
        GATH_READ: begin
          if (word_idx == 4'(`OCT_FEATURE_LENGTH - 1)) begin
            word_idx <= '0;
            if (anc_idx == ent_cnt - 1'b1) begin
              state <= GATH_POP;
            end else begin
              anc_idx <= anc_idx + 1'b1;
            end
          end else begin
            word_idx <= word_idx + 1'b1;
          end
        end
        default: state <= GATH_IDLE;
      endcase
    end
  end

  ////////////////////
  // output write
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
      out_we   <= 1'b0;
      out_ptr  <= '0;
    end else begin
      rd_valid <= (state == GATH_READ);
      out_we   <= rd_valid;
      if ((state == GATH_IDLE) && search_start) begin
        out_ptr <= '0;
      end else if (out_we) begin
        out_ptr <= out_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      out_wdata <= mem_rdata;
    end
  end

  assign out_cen  = ~out_we;
  assign out_gwen = ~out_we;
  assign out_addr = out_ptr;

endmodule

//--- search_sequencer.sv
`timescale 1ns/1ns
`include "octree_defines.svh"

module search_sequencer
  import octree_geom_pkg::*;
  import search_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       search_start,
  input  tree_idx_t                  tree_num,
  input  logic [`OCT_TREE_LEVEL-1:0] lod_active,
  input  logic                       fetch_done,
  input  logic                       gather_done,
  input  sram_addr_t                 fetch_addr,
  input  logic                       fetch_cen,
  input  sram_addr_t                 gather_addr,
  input  logic                       gather_cen,
  output logic                       fetch_start,
  output logic                       gather_start,
  output tree_idx_t                  tree_idx,
  output logic [`OCT_TREE_LEVEL-1:0] lod_mask,
  output logic                       search_done,
  output logic                       mem_cen,
  output logic                       mem_gwen,
  output sram_addr_t                 mem_addr,
  output sram_word_t                 mem_wdata
);

  seq_state_t state;
  tree_idx_t  tree_total;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= SEQ_IDLE;
      tree_idx     <= '0;
      tree_total   <= '0;
      lod_mask     <= '0;
      fetch_start  <= 1'b0;
      gather_start <= 1'b0;
      search_done  <= 1'b0;
    end else begin
      fetch_start  <= 1'b0;
      gather_start <= 1'b0;
      search_done  <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (search_start) begin
            lod_mask   <= lod_active;
            tree_idx   <= '0;
            tree_total <= (tree_num > tree_idx_t'(`OCT_MAX_TREES)) ?
                          tree_idx_t'(`OCT_MAX_TREES) : tree_num;
            if (tree_num == '0) begin
              search_done <= 1'b1;
              state       <= SEQ_DONE;
            end else begin
              fetch_start <= 1'b1;
              state       <= SEQ_SEARCH;
            end
          end
        end
        SEQ_SEARCH: begin
          if (fetch_done) begin
            gather_start <= 1'b1;
            state        <= SEQ_OUT;
          end
        end
        SEQ_OUT: begin
          if (gather_done) begin
            if (tree_idx == tree_total - 1'b1) begin
              search_done <= 1'b1;
              state       <= SEQ_DONE;
            end else begin
              tree_idx    <= tree_idx + 1'b1;
              fetch_start <= 1'b1;
              state       <= SEQ_SEARCH;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  ////////////////////
  // local memory port
  ////////////////////

  assign mem_cen   = (state == SEQ_SEARCH) ? fetch_cen :
                     (state == SEQ_OUT)    ? gather_cen : 1'b1;
  assign mem_addr  = (state == SEQ_SEARCH) ? fetch_addr :
                     (state == SEQ_OUT)    ? gather_addr : '0;
  // read only
  assign mem_gwen  = 1'b1;
  assign mem_wdata = '0;

  // a request from the phase that does not own the port would be lost
  a_fetch_owns : assert property (@(posedge clk) disable iff (!rst_n)
    !fetch_cen |-> state == SEQ_SEARCH);
  a_gather_owns : assert property (@(posedge clk) disable iff (!rst_n)
    !gather_cen |-> state == SEQ_OUT);

endmodule

//--- octree_searcher.sv
`timescale 1ns/1ns
`include "octree_defines.svh"

module octree_searcher
  import octree_geom_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       search_start,
  input  tree_idx_t                  tree_num,
  input  logic [`OCT_TREE_LEVEL-1:0] lod_active,
  output logic                       search_done,
  output logic                       mem_cen,
  output logic                       mem_gwen,
  output sram_addr_t                 mem_addr,
  output sram_word_t                 mem_wdata,
  input  sram_word_t                 mem_rdata,
  output logic                       out_cen,
  output logic                       out_gwen,
  output sram_addr_t                 out_addr,
  output sram_word_t                 out_wdata
);

  // phase handshakes
  logic                       fetch_start;
  logic                       fetch_done;
  logic                       gather_start;
  logic                       gather_done;
  tree_idx_t                  tree_idx;
  logic [`OCT_TREE_LEVEL-1:0] lod_mask;

  // local memory requests
  sram_addr_t fetch_addr;
  logic       fetch_cen;
  sram_addr_t gather_addr;
  logic       gather_cen;

  // queues
  logic         child_wr_en;
  queue_entry_t child_wr_data;
  logic         child_rd_en;
  queue_entry_t child_rd_data;
  logic         child_empty;
  logic         anchor_wr_en;
  queue_entry_t anchor_wr_data;
  logic         anchor_rd_en;
  queue_entry_t anchor_rd_data;
  logic         anchor_empty;

  search_sequencer u_search_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_start (search_start),
    .tree_num     (tree_num),
    .lod_active   (lod_active),
    .fetch_done   (fetch_done),
    .gather_done  (gather_done),
    .fetch_addr   (fetch_addr),
    .fetch_cen    (fetch_cen),
    .gather_addr  (gather_addr),
    .gather_cen   (gather_cen),
    .fetch_start  (fetch_start),
    .gather_start (gather_start),
    .tree_idx     (tree_idx),
    .lod_mask     (lod_mask),
    .search_done  (search_done),
    .mem_cen      (mem_cen),
    .mem_gwen     (mem_gwen),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata)
  );

  node_fetch u_node_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_start    (fetch_start),
    .tree_idx       (tree_idx),
    .lod_mask       (lod_mask),
    .mem_rdata      (mem_rdata),
    .child_rd_data  (child_rd_data),
    .child_empty    (child_empty),
    .fetch_addr     (fetch_addr),
    .fetch_cen      (fetch_cen),
    .child_wr_en    (child_wr_en),
    .child_wr_data  (child_wr_data),
    .child_rd_en    (child_rd_en),
    .anchor_wr_en   (anchor_wr_en),
    .anchor_wr_data (anchor_wr_data),
    .fetch_done     (fetch_done)
  );

  feature_gather u_feature_gather (
    .clk            (clk),
    .rst_n          (rst_n),
    .search_start   (search_start),
    .gather_start   (gather_start),
    .anchor_rd_data (anchor_rd_data),
    .anchor_empty   (anchor_empty),
    .mem_rdata      (mem_rdata),
    .anchor_rd_en   (anchor_rd_en),
    .gather_addr    (gather_addr),
    .gather_cen     (gather_cen),
    .out_cen        (out_cen),
    .out_gwen       (out_gwen),
    .out_addr       (out_addr),
    .out_wdata      (out_wdata),
    .gather_done    (gather_done)
  );

  anchor_fifo #(
    .DEPTH (`OCT_CHILD_DEPTH),
    .WIDTH ($bits(queue_entry_t))
  ) u_child_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (child_wr_en),
    .wr_data (child_wr_data),
    .rd_en   (child_rd_en),
    .rd_data (child_rd_data),
    .empty   (child_empty),
    .full    ()
  );

  anchor_fifo #(
    .DEPTH (`OCT_ANCHOR_DEPTH),
    .WIDTH ($bits(queue_entry_t))
  ) u_anchor_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (anchor_wr_en),
    .wr_data (anchor_wr_data),
    .rd_en   (anchor_rd_en),
    .rd_data (anchor_rd_data),
    .empty   (anchor_empty),
    .full    ()
  );

endmodule

//--- tb_sram_model.sv
`timescale 1ns/1ns

module tb_sram_model
  import octree_geom_pkg::*;
(
  input  logic       clk,
  input  logic       cen,
  input  logic       gwen,
  input  sram_addr_t addr,
  input  sram_word_t wdata,
  output sram_word_t q
);

  sram_word_t mem [1024];

  initial begin
    q <= '0;
  end

  // one-cycle read, write when gwen is low too
  always @(posedge clk) begin
    if (!cen) begin
      if (!gwen) begin
        mem[addr] <= wdata;
      end else begin
        q <= mem[addr];
      end
    end
  end

endmodule

//--- tb_octree_searcher.sv
`timescale 1ns/1ns
`include "octree_defines.svh"

module tb_octree_searcher
  import octree_geom_pkg::*;
();

  // test 5 is the longest at under 100 anchors, about 1300 cycles
  localparam int MAX_CYCLES = 20000;
  localparam int WAIT_LIMIT = 5000;
  localparam int MEM_WORDS  = 1024;

  logic                       clk;
  logic                       rst_n;
  logic                       search_start;
  tree_idx_t                  tree_num;
  logic [`OCT_TREE_LEVEL-1:0] lod_active;
  logic                       search_done;
  logic                       mem_cen;
  logic                       mem_gwen;
  sram_addr_t                 mem_addr;
  sram_word_t                 mem_wdata;
  sram_word_t                 mem_rdata;
  logic                       out_cen;
  logic                       out_gwen;
  sram_addr_t                 out_addr;
  sram_word_t                 out_wdata;

  sram_word_t local_img [MEM_WORDS];
  sram_word_t exp_words [$];
  sram_addr_t got_addr [$];
  sram_word_t got_data [$];
  int         deep_reads;
  int         error_count;
  int         test_count;
  int         cycle_count;
  int         seed;

  octree_searcher u_octree_searcher (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_start (search_start),
    .tree_num     (tree_num),
    .lod_active   (lod_active),
    .search_done  (search_done),
    .mem_cen      (mem_cen),
    .mem_gwen     (mem_gwen),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .out_cen      (out_cen),
    .out_gwen     (out_gwen),
    .out_addr     (out_addr),
    .out_wdata    (out_wdata)
  );

  tb_sram_model u_local_mem (
    .clk   (clk),
    .cen   (mem_cen),
    .gwen  (mem_gwen),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .q     (mem_rdata)
  );

  tb_sram_model u_out_mem (
    .clk   (clk),
    .cen   (out_cen),
    .gwen  (out_gwen),
    .addr  (out_addr),
    .wdata (out_wdata),
    .q     ()
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // output writes in order, and reads of words that hold only level-2 nodes of tree 0
  always @(negedge clk) begin
    if (rst_n && !out_cen && !out_gwen) begin
      got_addr.push_back(out_addr);
      got_data.push_back(out_wdata);
    end
    if (rst_n && !mem_cen && mem_addr >= 10'd3 && mem_addr <= 10'd18) begin
      deep_reads++;
    end
    // local memory is read only
    if (rst_n && (mem_gwen !== 1'b1 || mem_wdata !== '0)) begin
      $display("** Error: mem_gwen = 0x%h, mem_wdata = 0x%h, expected 0x1 and 0x0",
               mem_gwen, mem_wdata);
      error_count++;
    end
  end

  ////////////////////
  // memory image
  ////////////////////

  task automatic clear_image();
    for (int a = 0; a < MEM_WORDS; a++) begin
      local_img[a] = (a >= `OCT_FEATURE_START) ? 64'hFEA0_0000_0000 + 64'(a) : '0;
    end
  endtask

  // child bits on even positions, anchor bits on odd
  task automatic set_node(input int tree, input int slot, input logic [7:0] child,
                          input logic [7:0] anchor);
    int          word;
    logic [15:0] lane;
    word = `OCT_TREE_START + `OCT_TREE_STRIDE * tree + slot / 4;
    for (int j = 0; j < 8; j++) begin
      lane[2*j]   = child[j];
      lane[2*j+1] = anchor[j];
    end
    local_img[word][16*(slot%4) +: 16] = lane;
  endtask

  task load_image();
    for (int a = 0; a < MEM_WORDS; a++) begin
      u_local_mem.mem[a] <= local_img[a];
      u_out_mem.mem[a]   <= '0;
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic int anchor_hash(input int tree, input int alvl, input int o1,
                                     input int o2, input int j);
    int off [4];
    int primes [4];
    int h;
    off    = '{tree, o1, o2, 0};
    primes = '{`OCT_PRIME_0, `OCT_PRIME_1, `OCT_PRIME_2, `OCT_PRIME_3};
    off[alvl] = j;
    h = 0;
    for (int i = 0; i <= alvl; i++) begin
      h = h ^ ((off[i] + 1) * primes[i]);
    end
    return h & 63;
  endfunction

  // breadth-first walk over a node queue, one tree after the other
  task automatic build_expected(input int trees, input logic [3:0] lod);
    int          q_lvl [$];
    int          q_o1 [$];
    int          q_o2 [$];
    int          lvl;
    int          o1;
    int          o2;
    int          slot;
    int          h;
    int          code;
    logic [15:0] lane;
    exp_words.delete();
    for (int t = 0; t < trees; t++) begin
      q_lvl.push_back(0);
      q_o1.push_back(0);
      q_o2.push_back(0);
      while (q_lvl.size() > 0) begin
        lvl  = q_lvl.pop_front();
        o1   = q_o1.pop_front();
        o2   = q_o2.pop_front();
        slot = (lvl == 0) ? 0 : (lvl == 1) ? `OCT_SLOT_BASE_L1 + o1
                                           : `OCT_SLOT_BASE_L2 + 8 * o1 + o2;
        lane = local_img[`OCT_TREE_START + `OCT_TREE_STRIDE * t + slot / 4][16*(slot%4) +: 16];
        for (int j = 0; j < 8; j++) begin
          if (lod[lvl] && lane[2*j+1]) begin
            h = anchor_hash(t, lvl + 1, o1, o2, j);
            if (h > `OCT_HASH_LIMIT) begin
              code = h;
            end else begin
              code = h + `OCT_HASH_SHIFT;
            end
            for (int k = 0; k < `OCT_FEATURE_LENGTH; k++) begin
              exp_words.push_back(local_img[`OCT_FEATURE_START + `OCT_FEATURE_LENGTH * code + k]);
            end
          end
        end
        for (int j = 0; j < 8; j++) begin
          if (lvl < 2 && lod[lvl+1] && lane[2*j]) begin
            q_lvl.push_back(lvl + 1);
            q_o1.push_back((lvl == 0) ? j : o1);
            q_o2.push_back((lvl == 1) ? j : o2);
          end
        end
      end
    end
  endtask

  ////////////////////
  // drive and check
  ////////////////////

  task automatic run_search(input tree_idx_t trees, input logic [3:0] lod);
    int waited;
    got_addr.delete();
    got_data.delete();
    deep_reads   = 0;
    tree_num     = trees;
    lod_active   = lod;
    search_start = 1'b1;
    waited       = 0;
    do begin
      @(negedge clk);
      search_start = 1'b0;
      waited++;
    end while (!search_done && waited < WAIT_LIMIT);
    if (!search_done) begin
      $display("search_done did not arrive within %0d cycles", WAIT_LIMIT);
      error_count++;
    end
    @(negedge clk);
  endtask

  task automatic check_output();
    int n;
    if (got_addr.size() != exp_words.size()) begin
      $display("** Error: out_cen write count = 0x%0h, expected 0x%0h",
               got_addr.size(), exp_words.size());
      error_count++;
    end
    n = (got_addr.size() < exp_words.size()) ? got_addr.size() : exp_words.size();
    for (int i = 0; i < n; i++) begin
      if (got_addr[i] != sram_addr_t'(i)) begin
        $display("** Error: out_addr at write %0d = 0x%h, expected 0x%h",
                 i, got_addr[i], sram_addr_t'(i));
        error_count++;
      end
      if (got_data[i] != exp_words[i]) begin
        $display("** Error: out_wdata at write %0d = 0x%h, expected 0x%h",
                 i, got_data[i], exp_words[i]);
        error_count++;
      end
      if (u_out_mem.mem[i] != exp_words[i]) begin
        $display("** Error: output memory word %0d = 0x%h, expected 0x%h",
                 i, u_out_mem.mem[i], exp_words[i]);
        error_count++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic full_root_walk();
    int errs;
    errs = error_count;
    clear_image();
    set_node(0, 0, 8'hFF, 8'hFF);
    load_image();
    build_expected(1, 4'hF);
    run_search(4'd1, 4'hF);
    check_output();
    report_test("test 1 full root", errs);
  endtask

  // level-1 nodes carry only children, level-2 nodes only anchors
  task automatic lod_level_gate();
    int errs;
    errs = error_count;
    clear_image();
    set_node(0, 0, 8'hFF, 8'h3C);
    for (int o1 = 0; o1 < 8; o1++) begin
      set_node(0, `OCT_SLOT_BASE_L1 + o1, 8'h0F, 8'h00);
      for (int o2 = 0; o2 < 8; o2++) begin
        set_node(0, `OCT_SLOT_BASE_L2 + 8 * o1 + o2, 8'h00, 8'h81);
      end
    end
    load_image();
    build_expected(1, 4'b1011);
    run_search(4'd1, 4'b1011);
    check_output();
    if (deep_reads != 0) begin
      $display("** Error: level-2 node reads = 0x%0h, expected 0x0", deep_reads);
      error_count++;
    end
    report_test("test 2 lod gate", errs);
  endtask

  task automatic three_tree_order();
    int errs;
    errs = error_count;
    clear_image();
    for (int t = 0; t < 3; t++) begin
      set_node(t, 0, 8'h01 << t, 8'h81 >> t);
      set_node(t, `OCT_SLOT_BASE_L1 + t, 8'h01, 8'h03 << t);
      set_node(t, `OCT_SLOT_BASE_L2 + 8 * t, 8'h00, 8'h10 << t);
    end
    // tree 3 lies outside the search
    set_node(3, 0, 8'h00, 8'hFF);
    load_image();
    build_expected(3, 4'hF);
    run_search(4'd3, 4'hF);
    check_output();
    report_test("test 3 three trees", errs);
  endtask

  task automatic empty_root_restart();
    int errs;
    errs = error_count;
    clear_image();
    load_image();
    build_expected(2, 4'hF);
    run_search(4'd2, 4'hF);
    check_output();
    set_node(0, 0, 8'h00, 8'h18);
    load_image();
    build_expected(1, 4'hF);
    run_search(4'd1, 4'hF);
    check_output();
    report_test("test 4 empty root and restart", errs);
  endtask

  task automatic random_mask_walk();
    int errs;
    int r;
    errs = error_count;
    seed = 10;
    clear_image();
    // slots 0 to 72 of each tree, sparse enough to fit the output memory
    for (int t = 0; t < 4; t++) begin
      for (int s = 0; s <= `OCT_SLOT_BASE_L2 + 63; s++) begin
        r = $random(seed);
        if (s == 0) begin
          set_node(t, s, r[7:0] & 8'h55, r[15:8] & 8'h0F);
        end else if (s < `OCT_SLOT_BASE_L2) begin
          set_node(t, s, r[7:0] & 8'h11, r[15:8] & 8'h03);
        end else begin
          set_node(t, s, r[7:0], r[15:8] & 8'h01);
        end
      end
    end
    // root anchors 0 and 7 of tree 0 land on both sides of the fold
    local_img[0][1]  = 1'b1;
    local_img[0][15] = 1'b1;
    load_image();
    build_expected(4, 4'hF);
    run_search(4'd4, 4'hF);
    check_output();
    report_test("test 5 random masks", errs);
  endtask

  initial begin
    rst_n        = 1'b0;
    search_start = 1'b0;
    tree_num     = '0;
    lod_active   = '0;
    error_count  = 0;
    test_count   = 0;
    deep_reads   = 0;
    seed         = 10;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    full_root_walk();
    lod_level_gate();
    three_tree_order();
    empty_root_restart();
    random_mask_walk();
    $display("tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
octree_geom_pkg.sv
search_ctrl_pkg.sv
anchor_fifo.sv
node_fetch.sv
feature_gather.sv
search_sequencer.sv
octree_searcher.sv
tb_sram_model.sv
tb_octree_searcher.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_octree_searcher
RTL_TOP    ?= octree_searcher
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
